// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // One serial data byte, sent and received least significant bit first.
  typedef logic [7:0] uart_byte_t;

  // Wide enough to count the clocks in one bit cell.
  typedef logic [3:0] bit_cnt_t;

  // The system clock runs at 16 times the bit rate, so no baud generator is needed.
  localparam int CLKS_PER_BIT = 16;

  localparam int HALF_BIT = 8;   // From the start edge to the start-bit center.

  localparam int DATA_BITS = 8;  // 8N1 framing.

endpackage

// ==== rtl/cmd_pkg.sv ====
package cmd_pkg;

  // The opcode sits in the upper nibble of the first command byte.
  // Any other nibble value is an unknown opcode and gets the error reply.
  typedef enum logic [3:0] {
    OP_WRITE = 4'd1,
    OP_READ  = 4'd2,
    OP_ADD   = 4'd3,
    OP_CLEAR = 4'd4
  } opcode_t;

  typedef logic [1:0] reg_idx_t;  // Bits 1:0 of the first byte.

  localparam int NUM_REGS = 4;

  localparam logic [7:0] ERR_REPLY = 8'hEE;

  // One decoded command. The operand is only meaningful for WRITE and ADD.
  typedef struct packed {
    opcode_t    op;
    reg_idx_t   idx;
    logic [7:0] operand;
  } cmd_t;

  typedef struct packed {
    logic [7:0] data;
  } reply_t;

endpackage

// ==== rtl/uart_rx.sv ====
module uart_rx (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic                 uart_rx_line,
  output uart_pkg::uart_byte_t rx_byte,
  output logic                 rx_ready
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_CENTER,
    RX_WAIT,
    RX_SAMPLE,
    RX_STOP
  } rx_state_t;

  rx_state_t  state;
  rx_state_t  next_state;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       start_edge;
  bit_cnt_t   cell_cnt;
  bit_cnt_t   bits_rcvd;
  uart_byte_t shift_q;
  logic       cell_clr;
  logic       shift_en;
  logic       bits_clr;
  logic       ready_next;

  // Two flops bring the line into the clock domain, the third finds the falling edge.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= uart_rx_line;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // A start needs a real falling edge. After a low stop bit the line must go high first.
  assign start_edge = rx_prev & ~rx_sync;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cell_cnt  <= '0;
      bits_rcvd <= '0;
    end else begin
      if (cell_clr) begin
        cell_cnt <= '0;
      end else begin
        cell_cnt <= cell_cnt + 1'b1;
      end
      if (bits_clr) begin
        bits_rcvd <= '0;
      end else if (shift_en) begin
        bits_rcvd <= bits_rcvd + 1'b1;
      end
    end
  end

  // Fills from the top, so the first bit on the line ends up in bit 0.
  always_ff @(posedge sys_clk) begin
    if (shift_en) begin
      shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
    end
  end

  always_comb begin
    next_state = state;
    cell_clr   = 1'b1;
    shift_en   = 1'b0;
    bits_clr   = 1'b0;
    ready_next = 1'b0;
    case (state)
      RX_IDLE: begin
        bits_clr = 1'b1;
        if (start_edge) begin
          next_state = RX_CENTER;
        end
      end
      RX_CENTER: begin
        if (cell_cnt == bit_cnt_t'(HALF_BIT - 1)) begin
          next_state = rx_sync ? RX_IDLE : RX_WAIT;  // High at the center is a glitch.
        end else begin
          cell_clr = 1'b0;
        end
      end
      RX_WAIT: begin
        // The sample cycle itself makes up the last clock of the bit cell.
        if (cell_cnt == bit_cnt_t'(CLKS_PER_BIT - 2)) begin
          next_state = (bits_rcvd == bit_cnt_t'(DATA_BITS)) ? RX_STOP : RX_SAMPLE;
        end else begin
          cell_clr = 1'b0;
        end
      end
      RX_SAMPLE: begin
        shift_en   = 1'b1;
        next_state = RX_WAIT;
      end
      RX_STOP: begin
        ready_next = rx_sync;  // A low stop bit drops the frame.
        next_state = RX_IDLE;
      end
      default: begin
        next_state = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state    <= RX_IDLE;
      rx_ready <= 1'b0;
    end else begin
      state    <= next_state;
      rx_ready <= ready_next;
    end
  end

  assign rx_byte = shift_q;

endmodule

// ==== rtl/cmd_decode.sv ====
module cmd_decode (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  uart_pkg::uart_byte_t rx_byte,
  input  logic                 rx_ready,
  output cmd_pkg::cmd_t        cmd,
  output logic                 cmd_valid
);
  import cmd_pkg::*;

  typedef enum logic {
    DEC_OPCODE,
    DEC_OPERAND
  } dec_state_t;

  dec_state_t state;
  opcode_t    byte_op;
  logic       takes_operand;

  assign byte_op = opcode_t'(rx_byte[7:4]);

  // Only WRITE and ADD carry a second byte. Unknown opcodes issue at once.
  assign takes_operand = (byte_op == OP_WRITE) || (byte_op == OP_ADD);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state     <= DEC_OPCODE;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_ready) begin
        case (state)
          DEC_OPCODE: begin
            if (takes_operand) begin
              state <= DEC_OPERAND;
            end else begin
              cmd_valid <= 1'b1;
            end
          end
          DEC_OPERAND: begin
            cmd_valid <= 1'b1;
            state     <= DEC_OPCODE;
          end
          default: begin
            state <= DEC_OPCODE;
          end
        endcase
      end
    end
  end

  // The opcode byte fills op and idx, the operand byte fills the rest.
  always_ff @(posedge sys_clk) begin
    if (rx_ready) begin
      if (state == DEC_OPCODE) begin
        cmd.op  <= byte_op;
        cmd.idx <= reg_idx_t'(rx_byte[1:0]);
      end else begin
        cmd.operand <= rx_byte;
      end
    end
  end

endmodule

// ==== rtl/cmd_execute.sv ====
module cmd_execute (
  input  logic            sys_clk,
  input  logic            sys_rst_l,
  input  cmd_pkg::cmd_t   cmd,
  input  logic            cmd_valid,
  output cmd_pkg::reply_t reply,
  output logic            reply_valid
);
  import cmd_pkg::*;

  logic [7:0] regs [NUM_REGS];
  logic [7:0] cur_val;
  logic [7:0] sum_val;
  logic [7:0] reply_data;
  logic       has_reply;

  assign cur_val = regs[cmd.idx];
  assign sum_val = cur_val + cmd.operand;  // Wraps modulo 256.

  // WRITE, ADD and CLEAR change only the addressed register.
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cmd_valid) begin
      case (cmd.op)
        OP_WRITE: regs[cmd.idx] <= cmd.operand;
        OP_ADD:   regs[cmd.idx] <= sum_val;
        OP_CLEAR: regs[cmd.idx] <= '0;
        default: begin
        end
      endcase
    end
  end

  // READ returns the value before this cycle, ADD the new sum.
  always_comb begin
    case (cmd.op)
      OP_READ: reply_data = cur_val;
      OP_ADD:  reply_data = sum_val;
      default: reply_data = ERR_REPLY;
    endcase
  end

  assign has_reply = (cmd.op != OP_WRITE) && (cmd.op != OP_CLEAR);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      reply_valid <= 1'b0;
    end else begin
      reply_valid <= cmd_valid && has_reply;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cmd_valid && has_reply) begin
      reply.data <= reply_data;
    end
  end

endmodule

// ==== rtl/result_tx.sv ====
module result_tx (
  input  logic            sys_clk,
  input  logic            sys_rst_l,
  input  cmd_pkg::reply_t reply,
  input  logic            reply_valid,
  output logic            uart_tx
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t  state;
  bit_cnt_t   cell_cnt;
  bit_cnt_t   data_cnt;
  uart_byte_t tx_shift;
  uart_byte_t buf_data;
  logic       buf_full;
  logic       cell_end;
  logic       tx_free;
  logic       take_buf;
  logic       take_new;
  logic       hold_new;

  assign cell_end = (cell_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

  // The next frame may start when idle or straight after the last stop-bit clock.
  assign tx_free  = (state == TX_IDLE) || ((state == TX_STOP) && cell_end);
  assign take_buf = tx_free && buf_full;
  assign take_new = tx_free && !buf_full && reply_valid;
  assign hold_new = reply_valid && !take_new;  // Parks the reply while a frame is out.

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state    <= TX_IDLE;
      buf_full <= 1'b0;
      cell_cnt <= '0;
      data_cnt <= '0;
    end else begin
      if (hold_new) begin
        buf_full <= 1'b1;
      end else if (take_buf) begin
        buf_full <= 1'b0;
      end
      if ((state == TX_IDLE) || cell_end) begin
        cell_cnt <= '0;
      end else begin
        cell_cnt <= cell_cnt + 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (take_buf || take_new) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          if (cell_end) begin
            state    <= TX_DATA;
            data_cnt <= '0;
          end
        end
        TX_DATA: begin
          if (cell_end) begin
            data_cnt <= data_cnt + 1'b1;
            if (data_cnt == bit_cnt_t'(DATA_BITS - 1)) begin
              state <= TX_STOP;
            end
          end
        end
        TX_STOP: begin
          if (cell_end) begin
            state <= (take_buf || take_new) ? TX_START : TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (hold_new) begin
      buf_data <= reply.data;
    end
    if (take_buf) begin
      tx_shift <= buf_data;
    end else if (take_new) begin
      tx_shift <= reply.data;
    end else if ((state == TX_DATA) && cell_end) begin
      tx_shift <= tx_shift >> 1;  // Least significant bit goes out first.
    end
  end

  always_comb begin
    case (state)
      TX_START: uart_tx = 1'b0;
      TX_DATA:  uart_tx = tx_shift[0];
      default:  uart_tx = 1'b1;  // Idle line and stop bit.
    endcase
  end

endmodule

// ==== rtl/reg_unit_top.sv ====
module reg_unit_top (
  input  logic sys_clk,
  input  logic sys_rst_l,
  input  logic uart_rx_line,
  output logic uart_tx
);
  import uart_pkg::*;
  import cmd_pkg::*;

  uart_byte_t rx_byte;
  logic       rx_ready;
  cmd_t       cmd;
  logic       cmd_valid;
  reply_t     reply;
  logic       reply_valid;

  uart_rx u_rx (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .uart_rx_line (uart_rx_line),
    .rx_byte      (rx_byte),
    .rx_ready     (rx_ready)
  );

  cmd_decode u_decode (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .rx_byte   (rx_byte),
    .rx_ready  (rx_ready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  cmd_execute u_execute (
    .sys_clk     (sys_clk),
    .sys_rst_l   (sys_rst_l),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .reply       (reply),
    .reply_valid (reply_valid)
  );

  // Replies go back out on the same bit rate as the commands came in.
  result_tx u_tx (
    .sys_clk     (sys_clk),
    .sys_rst_l   (sys_rst_l),
    .reply       (reply),
    .reply_valid (reply_valid),
    .uart_tx     (uart_tx)
  );

endmodule

// ==== test/reg_unit_tb.sv ====
module reg_unit_tb;
  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int FIELDS = 7;
  localparam int MAX_VECS = 64;
  localparam int START_TIMEOUT = 60 * CLKS_PER_BIT;
  localparam int SEND_TIMEOUT = 100 * CLKS_PER_BIT;
  localparam int QUIET_BITS = 30;
  localparam logic [31:0] LFSR_SEED = 32'd70824;
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

  logic        sys_clk;
  logic        sys_rst_l;
  logic        uart_rx_line;
  logic        uart_tx;
  logic [7:0]  vec_mem [512];
  uart_byte_t  send_q [$];
  uart_byte_t  exp_q [$];
  logic [31:0] lfsr;
  logic        send_done;
  int          check_errors;
  int          tests_run;
  int          tests_failed;

  reg_unit_top uut (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .uart_rx_line (uart_rx_line),
    .uart_tx      (uart_tx)
  );

  always #50 sys_clk = ~sys_clk;

  function automatic logic [7:0] field(input int v, input int k);
    return vec_mem[9'(v * FIELDS + k)];
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_MASK;
    end
    return n;
  endfunction

  function automatic string op_name(input uart_byte_t b);
    case (b[7:4])
      OP_WRITE: return "WRITE";
      OP_READ:  return "READ";
      OP_ADD:   return "ADD";
      OP_CLEAR: return "CLEAR";
      default:  return "unknown opcode";
    endcase
  endfunction

  // Entered and left a fixed delay after a rising edge.
  task automatic drive_bits(input logic b, input int clocks);
    if (clocks > 0) begin
      uart_rx_line = b;
      repeat (clocks) @(posedge sys_clk);
      #5;
    end
  endtask

  task automatic send_frame(input uart_byte_t data, input logic stop_bit);
    uart_byte_t d;
    d = data;
    drive_bits(1'b0, CLKS_PER_BIT);
    for (int i = 0; i < DATA_BITS; i++) begin
      drive_bits(d[0], CLKS_PER_BIT);
      d = d >> 1;
    end
    drive_bits(stop_bit, CLKS_PER_BIT);
  endtask

  task automatic send_batch(input logic [7:0] noise);
    if (noise == 8'd1) begin
      drive_bits(1'b0, 3);  // Far shorter than half a bit.
      drive_bits(1'b1, 2 * CLKS_PER_BIT);
    end else if (noise == 8'd2) begin
      send_frame(8'h20, 1'b0);  // A READ that the receiver must drop.
      drive_bits(1'b1, 2 * CLKS_PER_BIT);
    end
    foreach (send_q[i]) begin
      send_frame(send_q[i], 1'b1);
    end
    send_done = 1'b1;
  endtask

  task automatic check_idle(input int clocks);
    int   n;
    logic bad;
    n = 0;
    bad = 1'b0;
    while (n < clocks && !bad) begin
      @(negedge sys_clk);
      n++;
      bad = (uart_tx !== 1'b1);
    end
    assert (!bad) else begin
      $display("FAILED uart_tx on idle line: expected %h, got %h", 1'b1, uart_tx);
      check_errors++;
    end
  endtask

  // Outputs change on the rising edge, so the line is read on the falling one.
  task automatic receive_byte(output uart_byte_t data, output logic ok);
    int   waited;
    logic found;
    data = '0;
    ok = 1'b0;
    waited = 0;
    @(negedge sys_clk);
    while (uart_tx !== 1'b0 && waited < START_TIMEOUT) begin
      @(negedge sys_clk);
      waited++;
    end
    found = (uart_tx === 1'b0);
    assert (found) else begin
      $display("Timeout: no start bit on uart_tx within %0d clocks.", START_TIMEOUT);
      check_errors++;
    end
    if (found) begin
      repeat (HALF_BIT) @(negedge sys_clk);
      assert (uart_tx === 1'b0) else begin
        $display("FAILED uart_tx start bit: expected %h, got %h", 1'b0, uart_tx);
        check_errors++;
      end
      repeat (DATA_BITS) begin
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        data = {uart_tx, data[7:1]};
      end
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      assert (uart_tx === 1'b1) else begin
        $display("FAILED uart_tx stop bit: expected %h, got %h", 1'b1, uart_tx);
        check_errors++;
      end
      ok = 1'b1;
    end
  endtask

  task automatic watch_replies();
    uart_byte_t got;
    uart_byte_t exp_byte;
    logic       ok;
    logic       stray;
    logic       stray_val;
    int         n;
    while (exp_q.size() > 0) begin
      exp_byte = exp_q.pop_front();
      receive_byte(got, ok);
      if (ok) begin
        assert (got === exp_byte) else begin
          $display("FAILED uart_tx reply: expected %h, got %h", exp_byte, got);
          check_errors++;
        end
      end
    end
    n = 0;
    stray = 1'b0;
    stray_val = 1'b1;
    while (!send_done && n < SEND_TIMEOUT) begin
      @(negedge sys_clk);
      n++;
      if (uart_tx !== 1'b1) begin
        stray = 1'b1;
        stray_val = uart_tx;
      end
    end
    assert (send_done) else begin
      $display("Timeout: the command bytes were not sent within %0d clocks.", SEND_TIMEOUT);
      check_errors++;
    end
    assert (!stray) else begin
      $display("FAILED uart_tx while sending: expected %h, got %h", 1'b1, stray_val);
      check_errors++;
    end
    check_idle(QUIET_BITS * CLKS_PER_BIT);  // Any extra frame shows up here.
  endtask

  task automatic report_test(input string what, input int errors_before);
    tests_run++;
    if (check_errors == errors_before) begin
      $display("test %0d, %s: ok", tests_run, what);
    end else begin
      $display("test %0d, %s: failed", tests_run, what);
      tests_failed++;
    end
  endtask

  initial begin
    int         v;
    int         first;
    int         gap;
    int         errors_before;
    logic       chained;
    logic [7:0] noise;
    string      what;

    sys_clk = 1'b0;
    sys_rst_l = 1'b0;
    uart_rx_line = 1'b1;
    send_done = 1'b0;
    lfsr = LFSR_SEED;
    check_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < 512; i++) begin
      vec_mem[9'(i)] = '0;
    end
    $readmemh("test/golden_vectors.txt", vec_mem);

    repeat (16) @(posedge sys_clk);
    #5;
    sys_rst_l = 1'b1;

    errors_before = check_errors;
    check_idle(2 * CLKS_PER_BIT);
    @(posedge sys_clk);
    #5;
    report_test("idle line after reset", errors_before);

    v = 0;
    while (v < MAX_VECS && (field(v, 0) == 8'd1 || field(v, 0) == 8'd2)) begin
      first = v;
      noise = field(v, 3);
      chained = 1'b1;
      // Chained lines go out back to back, and their replies are read in order.
      while (chained && v < MAX_VECS && field(v, 0) != 8'd0) begin
        send_q.push_back(field(v, 1));
        if (field(v, 0) == 8'd2) begin
          send_q.push_back(field(v, 2));
        end
        if (field(v, 4) != 8'd0) begin
          exp_q.push_back(field(v, 5));
        end
        chained = (field(v, 6) != 8'd0);
        v++;
      end
      what = $sformatf("vector %0d %s, %0d command(s), noise %0d",
                       first, op_name(field(first, 1)), v - first, noise);
      gap = 0;
      repeat (4) begin
        lfsr = lfsr_step(lfsr);
        gap = (gap << 1) | int'(lfsr[0]);
      end
      drive_bits(1'b1, gap * CLKS_PER_BIT);
      errors_before = check_errors;
      send_done = 1'b0;
      fork
        send_batch(noise);
        watch_replies();
      join
      send_q.delete();
      @(posedge sys_clk);
      #5;
      report_test(what, errors_before);
    end

    assert (tests_run > 1) else begin
      $display("No command vectors were read from the golden file.");
      check_errors++;
    end
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             check_errors);
    if (check_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== test/golden_vectors.txt ====
// Columns: byte count, first byte, second byte, noise (0 none, 1 glitch, 2 low stop bit),
// reply expected, expected reply, chained to the next line (1 sends it with no idle gap).
1 20 00 0 1 00 0
1 21 00 0 1 00 0
1 22 00 0 1 00 0
1 23 00 0 1 00 0
2 10 5A 0 0 00 0
1 20 00 0 1 5A 0
2 11 C3 0 0 00 0
2 31 20 0 1 E3 0
2 31 40 0 1 23 0
1 21 00 0 1 23 0
2 12 FF 0 0 00 0
2 32 01 0 1 00 0
2 33 7F 0 1 7F 0
1 40 00 0 0 00 0
1 20 00 0 1 00 0
1 70 00 0 1 EE 1
1 23 00 0 1 7F 0
1 F1 00 0 1 EE 0
2 12 A5 1 0 00 0
1 22 00 1 1 A5 0
1 21 00 2 1 23 0
2 30 11 2 1 11 0
1 20 00 0 1 11 1
2 33 01 0 1 80 1
1 22 00 0 1 A5 1
2 11 99 0 0 00 1
1 21 00 0 1 99 0
1 42 00 0 0 00 1
1 22 00 0 1 00 0

// ==== tb.f ====
rtl/uart_pkg.sv
rtl/cmd_pkg.sv
rtl/uart_rx.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/result_tx.sv
rtl/reg_unit_top.sv
test/reg_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module reg_unit_tb -o reg_unit_sim

out=$(./obj_dir/reg_unit_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
